// ==== design/glb_if.sv ====
`timescale 1ns/1ps
`include "glb_settings.svh"

// processor packet, travels west to east
interface glb_proc_if
    import glb_pkg::*;
();
    // write request
    logic       wr_en;
    bank_strb_t wr_strb;
    glb_addr_t  wr_addr;
    bank_data_t wr_data;

    // read request
    logic       rd_en;
    glb_addr_t  rd_addr;

    // read response, filled in by the owning tile
    bank_data_t rd_data;
    logic       rd_data_valid;

    modport upstream (
        output wr_en, wr_strb, wr_addr, wr_data,
        output rd_en, rd_addr,
        output rd_data, rd_data_valid
    );

    modport downstream (
        input wr_en, wr_strb, wr_addr, wr_data,
        input rd_en, rd_addr,
        input rd_data, rd_data_valid
    );
endinterface

// configuration relay between tiles
interface glb_cfg_if ();
    logic                           wr_en;
    logic                           rd_en;
    logic [`GLB_CFG_ADDR_WIDTH-1:0] addr;
    logic [`GLB_CFG_DATA_WIDTH-1:0] data;

    modport upstream (
        output wr_en, rd_en, addr, data
    );

    modport downstream (
        input wr_en, rd_en, addr, data
    );
endinterface

// ==== design/glb_input_regs.sv ====
`timescale 1ns/1ps

module glb_input_regs
    import glb_pkg::*;
(
    input  logic       reset,
    input  logic       clk,

    // processor request
    input  logic       proc_wr_en,
    input  bank_strb_t proc_wr_strb,
    input  glb_addr_t  proc_wr_addr,
    input  bank_data_t proc_wr_data,
    input  logic       proc_rd_en,
    input  glb_addr_t  proc_rd_addr,

    // command from the global controller
    input  cgra_cfg_t  cfg_in,

    glb_proc_if.upstream proc_out,
    glb_cfg_if.upstream  cfg_out
);

    // request enables
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            proc_out.wr_en <= 1'b0;
            proc_out.rd_en <= 1'b0;
        end else begin
            proc_out.wr_en <= proc_wr_en;
            proc_out.rd_en <= proc_rd_en;
        end
    end

    // request payload
    always_ff @(posedge reset) begin
        proc_out.wr_strb <= proc_wr_strb;
        proc_out.wr_addr <= proc_wr_addr;
        proc_out.wr_data <= proc_wr_data;
        proc_out.rd_addr <= proc_rd_addr;
    end

    // no response yet at the west end of the chain
    assign proc_out.rd_data       = '0;
    assign proc_out.rd_data_valid = 1'b0;

    // controller command, cleared so the fabric sees zeros after reset
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            cfg_out.wr_en <= 1'b0;
            cfg_out.rd_en <= 1'b0;
            cfg_out.addr  <= '0;
            cfg_out.data  <= '0;
        end else begin
            cfg_out.wr_en <= cfg_in.cfg_wr_en;
            cfg_out.rd_en <= cfg_in.cfg_rd_en;
            cfg_out.addr  <= cfg_in.cfg_addr;
            cfg_out.data  <= cfg_in.cfg_data;
        end
    end

endmodule

// ==== design/glb_output_regs.sv ====
`timescale 1ns/1ps
`include "glb_settings.svh"

module glb_output_regs
    import glb_pkg::*;
(
    input  logic reset,
    input  logic clk,

    // east end of the processor pipeline
    glb_proc_if.downstream proc_in,

    input  cgra_cfg_cols_t cfg_g2f_in [`GLB_NUM_TILES],
    input  logic           cgra_stall_in,

    output bank_data_t proc_rd_data,
    output logic       proc_rd_data_valid,

    // fabric configuration ports
    output logic [`GLB_NUM_TILES-1:0][`GLB_CGRA_PER_TILE-1:0] cgra_cfg_g2f_cfg_wr_en,
    output logic [`GLB_NUM_TILES-1:0][`GLB_CGRA_PER_TILE-1:0] cgra_cfg_g2f_cfg_rd_en,
    output logic [`GLB_NUM_TILES-1:0][`GLB_CGRA_PER_TILE-1:0][`GLB_CFG_ADDR_WIDTH-1:0]
        cgra_cfg_g2f_cfg_addr,
    output logic [`GLB_NUM_TILES-1:0][`GLB_CGRA_PER_TILE-1:0][`GLB_CFG_DATA_WIDTH-1:0]
        cgra_cfg_g2f_cfg_data,

    output logic [`GLB_NUM_TILES-1:0][`GLB_CGRA_PER_TILE-1:0] cgra_stall
);

    logic stall_d1;
    logic stall_d2;

    // read response, data forced to zero when not valid
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            proc_rd_data       <= '0;
            proc_rd_data_valid <= 1'b0;
        end else begin
            proc_rd_data       <= proc_in.rd_data_valid ? proc_in.rd_data : '0;
            proc_rd_data_valid <= proc_in.rd_data_valid;
        end
    end

    // split the per-column structs into flat port groups
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            cgra_cfg_g2f_cfg_wr_en <= '0;
            cgra_cfg_g2f_cfg_rd_en <= '0;
            cgra_cfg_g2f_cfg_addr  <= '0;
            cgra_cfg_g2f_cfg_data  <= '0;
        end else begin
            for (int t = 0; t < `GLB_NUM_TILES; t++) begin
                for (int c = 0; c < `GLB_CGRA_PER_TILE; c++) begin
                    cgra_cfg_g2f_cfg_wr_en[t][c] <= cfg_g2f_in[t][c].cfg_wr_en;
                    cgra_cfg_g2f_cfg_rd_en[t][c] <= cfg_g2f_in[t][c].cfg_rd_en;
                    cgra_cfg_g2f_cfg_addr[t][c]  <= cfg_g2f_in[t][c].cfg_addr;
                    cgra_cfg_g2f_cfg_data[t][c]  <= cfg_g2f_in[t][c].cfg_data;
                end
            end
        end
    end

    // two-stage stall delay
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            stall_d1 <= 1'b0;
            stall_d2 <= 1'b0;
        end else begin
            stall_d1 <= cgra_stall_in;
            stall_d2 <= stall_d1;
        end
    end

    assign cgra_stall = {(`GLB_NUM_TILES * `GLB_CGRA_PER_TILE){stall_d2}};

endmodule

// ==== design/glb_pkg.sv ====
`include "glb_settings.svh"

package glb_pkg;

    // address field widths
    localparam int BYTE_OFFSET_WIDTH = $clog2(`GLB_BANK_DATA_WIDTH / 8);
    localparam int WORD_ADDR_WIDTH = $clog2(`GLB_BANK_WORDS);
    localparam int TILE_SEL_WIDTH = $clog2(`GLB_NUM_TILES);

    typedef logic [`GLB_ADDR_WIDTH-1:0] glb_addr_t;
    typedef logic [`GLB_BANK_DATA_WIDTH-1:0] bank_data_t;
    typedef logic [`GLB_BANK_DATA_WIDTH/8-1:0] bank_strb_t;
    typedef logic [WORD_ADDR_WIDTH-1:0] bank_word_addr_t;
    typedef logic [TILE_SEL_WIDTH-1:0] tile_sel_t;

    // one configuration command
    typedef struct packed {
        logic cfg_wr_en;
        logic cfg_rd_en;
        logic [`GLB_CFG_ADDR_WIDTH-1:0] cfg_addr;
        logic [`GLB_CFG_DATA_WIDTH-1:0] cfg_data;
    } cgra_cfg_t;

    // one command per fabric column of a tile
    typedef cgra_cfg_t [`GLB_CGRA_PER_TILE-1:0] cgra_cfg_cols_t;

    // word index inside a bank
    function automatic bank_word_addr_t addr_word(glb_addr_t addr);
        return addr[BYTE_OFFSET_WIDTH +: WORD_ADDR_WIDTH];
    endfunction

    // tile select field
    function automatic tile_sel_t addr_tile(glb_addr_t addr);
        return addr[BYTE_OFFSET_WIDTH + WORD_ADDR_WIDTH +: TILE_SEL_WIDTH];
    endfunction

endpackage

// ==== design/glb_settings.svh ====
`ifndef GLB_SETTINGS_SVH
`define GLB_SETTINGS_SVH

// tile chain
`define GLB_NUM_TILES 4

// fabric columns fed by one tile
`define GLB_CGRA_PER_TILE 2

// memory bank geometry
`define GLB_BANK_DATA_WIDTH 64
`define GLB_BANK_WORDS 256

// processor byte address, tile select on top
// 3 byte-offset bits, 8 word bits, 2 tile bits
`define GLB_ADDR_WIDTH 13

// configuration command from the global controller
`define GLB_CFG_ADDR_WIDTH 32
`define GLB_CFG_DATA_WIDTH 32

`endif

// ==== design/glb_tile.sv ====
`timescale 1ns/1ps
`include "glb_settings.svh"

module glb_tile
    import glb_pkg::*;
#(
    parameter int TILE_ID = 0
) (
    input  logic reset,
    input  logic clk,

    // west side in
    glb_proc_if.downstream proc_wsti,
    glb_cfg_if.downstream  cfg_wsti,

    // east side out
    glb_proc_if.upstream   proc_esto,
    glb_cfg_if.upstream    cfg_esto,

    // commands to the fabric columns below this tile
    output cgra_cfg_cols_t cfg_g2f
);

    localparam int STRB_WIDTH = `GLB_BANK_DATA_WIDTH / 8;

    bank_data_t bank_mem [`GLB_BANK_WORDS];

    logic            wr_hit;
    logic            rd_hit;
    bank_word_addr_t wr_word;
    bank_word_addr_t rd_word;

    cgra_cfg_t cfg_q;

    // request decode against this tile's select value
    assign wr_hit  = proc_wsti.wr_en && (addr_tile(proc_wsti.wr_addr) == tile_sel_t'(TILE_ID));
    assign rd_hit  = proc_wsti.rd_en && (addr_tile(proc_wsti.rd_addr) == tile_sel_t'(TILE_ID));
    assign wr_word = addr_word(proc_wsti.wr_addr);
    assign rd_word = addr_word(proc_wsti.rd_addr);

    // byte-masked write into the bank
    always_ff @(posedge reset) begin
        if (wr_hit) begin
            for (int b = 0; b < STRB_WIDTH; b++) begin
                if (proc_wsti.wr_strb[b]) begin
                    bank_mem[wr_word][b*8 +: 8] <= proc_wsti.wr_data[b*8 +: 8];
                end
            end
        end
    end

    // enables and response valid move one hop east
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            proc_esto.wr_en         <= 1'b0;
            proc_esto.rd_en         <= 1'b0;
            proc_esto.rd_data_valid <= 1'b0;
        end else begin
            proc_esto.wr_en         <= proc_wsti.wr_en;
            proc_esto.rd_en         <= proc_wsti.rd_en;
            proc_esto.rd_data_valid <= rd_hit | proc_wsti.rd_data_valid;
        end
    end

    // payload hop, read data is inserted by the owning tile
    always_ff @(posedge reset) begin
        proc_esto.wr_strb <= proc_wsti.wr_strb;
        proc_esto.wr_addr <= proc_wsti.wr_addr;
        proc_esto.wr_data <= proc_wsti.wr_data;
        proc_esto.rd_addr <= proc_wsti.rd_addr;
        if (rd_hit) begin
            // old contents on a same-cycle write to the same word
            proc_esto.rd_data <= bank_mem[rd_word];
        end else begin
            proc_esto.rd_data <= proc_wsti.rd_data;
        end
    end

    // configuration relay
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            cfg_q <= '0;
        end else begin
            cfg_q.cfg_wr_en <= cfg_wsti.wr_en;
            cfg_q.cfg_rd_en <= cfg_wsti.rd_en;
            cfg_q.cfg_addr  <= cfg_wsti.addr;
            cfg_q.cfg_data  <= cfg_wsti.data;
        end
    end

    assign cfg_esto.wr_en = cfg_q.cfg_wr_en;
    assign cfg_esto.rd_en = cfg_q.cfg_rd_en;
    assign cfg_esto.addr  = cfg_q.cfg_addr;
    assign cfg_esto.data  = cfg_q.cfg_data;

    // same command on every column
    always_comb begin
        for (int c = 0; c < `GLB_CGRA_PER_TILE; c++) begin
            cfg_g2f[c] = cfg_q;
        end
    end

endmodule

// ==== design/global_buffer.sv ====
`timescale 1ns/1ps
`include "glb_settings.svh"

module global_buffer
    import glb_pkg::*;
(
    input  logic       reset,
    input  logic       clk,
    input  logic       cgra_stall_in,

    // processor
    input  logic       proc_wr_en,
    input  bank_strb_t proc_wr_strb,
    input  glb_addr_t  proc_wr_addr,
    input  bank_data_t proc_wr_data,
    input  logic       proc_rd_en,
    input  glb_addr_t  proc_rd_addr,
    output bank_data_t proc_rd_data,
    output logic       proc_rd_data_valid,

    // global controller
    input  logic                           cgra_cfg_jtag_gc2glb_wr_en,
    input  logic                           cgra_cfg_jtag_gc2glb_rd_en,
    input  logic [`GLB_CFG_ADDR_WIDTH-1:0] cgra_cfg_jtag_gc2glb_addr,
    input  logic [`GLB_CFG_DATA_WIDTH-1:0] cgra_cfg_jtag_gc2glb_data,

    // fabric
    output logic [`GLB_NUM_TILES-1:0][`GLB_CGRA_PER_TILE-1:0] cgra_stall,
    output logic [`GLB_NUM_TILES-1:0][`GLB_CGRA_PER_TILE-1:0] cgra_cfg_g2f_cfg_wr_en,
    output logic [`GLB_NUM_TILES-1:0][`GLB_CGRA_PER_TILE-1:0] cgra_cfg_g2f_cfg_rd_en,
    output logic [`GLB_NUM_TILES-1:0][`GLB_CGRA_PER_TILE-1:0][`GLB_CFG_ADDR_WIDTH-1:0]
        cgra_cfg_g2f_cfg_addr,
    output logic [`GLB_NUM_TILES-1:0][`GLB_CGRA_PER_TILE-1:0][`GLB_CFG_DATA_WIDTH-1:0]
        cgra_cfg_g2f_cfg_data
);

    // hop i feeds tile i, the last one feeds the output side
    glb_proc_if proc_hop [`GLB_NUM_TILES+1] ();
    glb_cfg_if  cfg_hop [`GLB_NUM_TILES+1] ();

    cgra_cfg_t      jtag_cfg;
    cgra_cfg_cols_t cfg_g2f_int [`GLB_NUM_TILES];

    assign jtag_cfg.cfg_wr_en = cgra_cfg_jtag_gc2glb_wr_en;
    assign jtag_cfg.cfg_rd_en = cgra_cfg_jtag_gc2glb_rd_en;
    assign jtag_cfg.cfg_addr  = cgra_cfg_jtag_gc2glb_addr;
    assign jtag_cfg.cfg_data  = cgra_cfg_jtag_gc2glb_data;

    glb_input_regs glb_input_regs_i (
        .reset,
        .clk,
        .proc_wr_en,
        .proc_wr_strb,
        .proc_wr_addr,
        .proc_wr_data,
        .proc_rd_en,
        .proc_rd_addr,
        .cfg_in   (jtag_cfg),
        .proc_out (proc_hop[0]),
        .cfg_out  (cfg_hop[0])
    );

    for (genvar i = 0; i < `GLB_NUM_TILES; i++) begin : glb_tile_gen
        glb_tile #(
            .TILE_ID (i)
        ) glb_tile_i (
            .reset,
            .clk,
            .proc_wsti (proc_hop[i]),
            .cfg_wsti  (cfg_hop[i]),
            .proc_esto (proc_hop[i+1]),
            .cfg_esto  (cfg_hop[i+1]),
            .cfg_g2f   (cfg_g2f_int[i])
        );
    end

    glb_output_regs glb_output_regs_i (
        .reset,
        .clk,
        .proc_in    (proc_hop[`GLB_NUM_TILES]),
        .cfg_g2f_in (cfg_g2f_int),
        .cgra_stall_in,
        .proc_rd_data,
        .proc_rd_data_valid,
        .cgra_cfg_g2f_cfg_wr_en,
        .cgra_cfg_g2f_cfg_rd_en,
        .cgra_cfg_g2f_cfg_addr,
        .cgra_cfg_g2f_cfg_data,
        .cgra_stall
    );

endmodule

// ==== global_buffer.f ====
+incdir+design
design/glb_pkg.sv
design/glb_if.sv
design/glb_input_regs.sv
design/glb_tile.sv
design/glb_output_regs.sv
design/global_buffer.sv
testbench/tb_clock_gen.sv
testbench/global_buffer_tb.sv

// ==== testbench/global_buffer_tb.sv ====
`timescale 1ns/1ps
`include "glb_settings.svh"

module global_buffer_tb
    import glb_pkg::*;
();

    localparam int NT              = `GLB_NUM_TILES;
    localparam int NC              = `GLB_CGRA_PER_TILE;
    localparam int READ_LATENCY    = NT + 2;
    localparam int CFG_HIST_LEN    = NT + 2;
    localparam int WORDS_PER_TILE  = 4;
    localparam int POOL_SIZE       = NT * WORDS_PER_TILE;
    localparam int FILL_OPS        = 2 * POOL_SIZE;
    localparam int STRB_OPS        = 16;
    localparam int BURST_OPS       = 200;
    localparam int CFG_OPS         = 12;
    localparam int TOTAL_OPS       = FILL_OPS + STRB_OPS + BURST_OPS + CFG_OPS;
    localparam int WATCHDOG_CYCLES = 16 + TOTAL_OPS * 10;

    typedef struct {
        int unsigned due;
        bank_data_t  data;
    } pending_read_t;

    logic reset;
    logic clk;
    logic cgra_stall_in;
    logic proc_wr_en;
    bank_strb_t proc_wr_strb;
    glb_addr_t proc_wr_addr;
    bank_data_t proc_wr_data;
    logic proc_rd_en;
    glb_addr_t proc_rd_addr;
    bank_data_t proc_rd_data;
    logic proc_rd_data_valid;
    cgra_cfg_t cfg_cmd;
    logic [NT-1:0][NC-1:0] cgra_stall;
    logic [NT-1:0][NC-1:0] cgra_cfg_g2f_cfg_wr_en;
    logic [NT-1:0][NC-1:0] cgra_cfg_g2f_cfg_rd_en;
    logic [NT-1:0][NC-1:0][`GLB_CFG_ADDR_WIDTH-1:0] cgra_cfg_g2f_cfg_addr;
    logic [NT-1:0][NC-1:0][`GLB_CFG_DATA_WIDTH-1:0] cgra_cfg_g2f_cfg_data;

    // reference model and expected outputs for the coming edge
    bank_data_t ref_mem [NT * `GLB_BANK_WORDS];
    pending_read_t read_q [$];
    cgra_cfg_t cfg_hist [CFG_HIST_LEN];
    logic stall_hist [2];
    logic exp_valid = 1'b0;
    bank_data_t exp_data = '0;
    cgra_cfg_t exp_cfg [NT];
    logic exp_stall = 1'b0;
    glb_addr_t pool [POOL_SIZE];

    logic [31:0] rng_state = 32'h446e;
    int unsigned cyc = 0;
    int mismatches = 0;
    int other_errors = 0;
    int reads_due = 0;

    tb_clock_gen clock_gen_i (
        .reset,
        .clk
    );

    global_buffer global_buffer_i (
        .reset,
        .clk,
        .cgra_stall_in,
        .proc_wr_en,
        .proc_wr_strb,
        .proc_wr_addr,
        .proc_wr_data,
        .proc_rd_en,
        .proc_rd_addr,
        .proc_rd_data,
        .proc_rd_data_valid,
        .cgra_cfg_jtag_gc2glb_wr_en (cfg_cmd.cfg_wr_en),
        .cgra_cfg_jtag_gc2glb_rd_en (cfg_cmd.cfg_rd_en),
        .cgra_cfg_jtag_gc2glb_addr  (cfg_cmd.cfg_addr),
        .cgra_cfg_jtag_gc2glb_data  (cfg_cmd.cfg_data),
        .cgra_stall,
        .cgra_cfg_g2f_cfg_wr_en,
        .cgra_cfg_g2f_cfg_rd_en,
        .cgra_cfg_g2f_cfg_addr,
        .cgra_cfg_g2f_cfg_data
    );

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic bank_data_t random_word();
        return {next_random(), next_random()};
    endfunction

    // tile select on top, then word index, then 3 byte-offset bits
    function automatic glb_addr_t make_addr(input tile_sel_t tile, input bank_word_addr_t word,
                                            input logic [2:0] off);
        return {tile, word, off};
    endfunction

    function automatic int model_index(input glb_addr_t addr);
        return int'(addr[`GLB_ADDR_WIDTH-1:3]);
    endfunction

    // steps to the next falling edge and sets up expected values and idle inputs
    task automatic advance_cycle();
        logic [31:0] r;
        @(negedge reset);
        cyc++;
        for (int j = CFG_HIST_LEN - 1; j > 0; j--) begin
            cfg_hist[j] = cfg_hist[j-1];
        end
        cfg_hist[0] = cfg_cmd;
        stall_hist[1] = stall_hist[0];
        stall_hist[0] = cgra_stall_in;
        // tile i shows a command i+3 cycles after it is sampled
        for (int t = 0; t < NT; t++) begin
            exp_cfg[t] = cfg_hist[t+2];
        end
        exp_stall = stall_hist[1];
        if (read_q.size() != 0 && read_q[0].due == cyc) begin
            exp_valid = 1'b1;
            exp_data = read_q[0].data;
            void'(read_q.pop_front());
            reads_due++;
        end else begin
            exp_valid = 1'b0;
            exp_data = '0;
        end
        r = next_random();
        proc_wr_en = 1'b0;
        proc_rd_en = 1'b0;
        cfg_cmd = '0;
        cgra_stall_in = r[9];
    endtask

    task automatic write_op(input glb_addr_t addr, input bank_data_t data,
                            input bank_strb_t strb);
        int idx;
        advance_cycle();
        proc_wr_en = 1'b1;
        proc_wr_addr = addr;
        proc_wr_data = data;
        proc_wr_strb = strb;
        idx = model_index(addr);
        for (int b = 0; b < $bits(bank_strb_t); b++) begin
            if (strb[b]) begin
                ref_mem[idx][b*8 +: 8] = data[b*8 +: 8];
            end
        end
    endtask

    task automatic read_op(input glb_addr_t addr);
        pending_read_t p;
        advance_cycle();
        proc_rd_en = 1'b1;
        proc_rd_addr = addr;
        p.due = cyc + READ_LATENCY;
        p.data = ref_mem[model_index(addr)];
        read_q.push_back(p);
    endtask

    task automatic wait_reads_done();
        while (read_q.size() != 0) begin
            advance_cycle();
        end
    endtask

    assert property (@(posedge reset) clk |-> (!proc_rd_data_valid && proc_rd_data == '0
        && cgra_stall == '0 && cgra_cfg_g2f_cfg_wr_en == '0 && cgra_cfg_g2f_cfg_rd_en == '0
        && cgra_cfg_g2f_cfg_addr == '0 && cgra_cfg_g2f_cfg_data == '0))
        else begin
            mismatches++;
            $display("MISMATCH at %0t: outputs not zero during reset", $time);
        end

    assert property (@(posedge reset) disable iff (clk) proc_rd_data_valid |-> exp_valid)
        else begin
            other_errors++;
            $display("read response valid at %0t with no read due", $time);
        end

    assert property (@(posedge reset) disable iff (clk) exp_valid |-> proc_rd_data_valid)
        else begin
            other_errors++;
            $display("read response missing at %0t where one was due", $time);
        end

    assert property (@(posedge reset) disable iff (clk) exp_valid |-> proc_rd_data == exp_data)
        else begin
            mismatches++;
            $display("MISMATCH at %0t: read data expected %h got %h", $time,
                     $sampled(exp_data), $sampled(proc_rd_data));
        end

    assert property (@(posedge reset) disable iff (clk) !proc_rd_data_valid |-> proc_rd_data == '0)
        else begin
            mismatches++;
            $display("MISMATCH at %0t: read data not zero while invalid", $time);
        end

    assert property (@(posedge reset) disable iff (clk) cgra_stall == {(NT * NC){exp_stall}})
        else begin
            mismatches++;
            $display("MISMATCH at %0t: stall expected %b got %b", $time,
                     $sampled(exp_stall), $sampled(cgra_stall));
        end

    for (genvar t = 0; t < NT; t++) begin : cfg_check
        for (genvar c = 0; c < NC; c++) begin : col
            assert property (@(posedge reset) disable iff (clk)
                {cgra_cfg_g2f_cfg_wr_en[t][c], cgra_cfg_g2f_cfg_rd_en[t][c],
                 cgra_cfg_g2f_cfg_addr[t][c], cgra_cfg_g2f_cfg_data[t][c]} == exp_cfg[t])
                else begin
                    mismatches++;
                    $display("MISMATCH at %0t: tile %0d column %0d config expected %h", $time,
                             t, c, $sampled(exp_cfg[t]));
                end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge reset);
        $display("timeout after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        logic [31:0] r;
        glb_addr_t a;
        glb_addr_t last_addr;
        logic last_wr;
        bank_strb_t strb;
        proc_wr_en = 1'b0;
        proc_wr_strb = '0;
        proc_wr_addr = '0;
        proc_wr_data = '0;
        proc_rd_en = 1'b0;
        proc_rd_addr = '0;
        cfg_cmd = '0;
        cgra_stall_in = 1'b0;
        cfg_hist = '{default: '0};
        stall_hist = '{default: 1'b0};
        exp_cfg = '{default: '0};
        last_addr = '0;
        last_wr = 1'b0;

        // wait for the release of the asynchronous reset
        @(posedge clk);
        @(negedge clk);
        @(posedge reset);

        // full-word write then read of a few words in every tile
        for (int t = 0; t < NT; t++) begin
            for (int k = 0; k < WORDS_PER_TILE; k++) begin
                r = next_random();
                pool[t*WORDS_PER_TILE + k] = make_addr(tile_sel_t'(t), r[7:0], r[10:8]);
                write_op(pool[t*WORDS_PER_TILE + k], random_word(), '1);
                read_op(make_addr(tile_sel_t'(t), r[7:0], r[13:11]));
                wait_reads_done();
            end
        end

        // byte strobes merge with the old word
        for (int n = 0; n < STRB_OPS / 2; n++) begin
            r = next_random();
            a = pool[r[15:8] % POOL_SIZE];
            write_op(a, random_word(), r[7:0]);
            read_op(a);
            wait_reads_done();
        end

        // back-to-back mix with frequent reads right after a write to the same word
        for (int n = 0; n < BURST_OPS; n++) begin
            r = next_random();
            if (last_wr && r[0]) begin
                read_op(last_addr);
                last_wr = 1'b0;
            end else begin
                a = pool[r[7:4] % POOL_SIZE];
                a[2:0] = r[10:8];
                strb = r[2] ? '1 : r[23:16];
                if (r[1]) begin
                    write_op(a, random_word(), strb);
                    last_wr = 1'b1;
                    last_addr = a;
                end else begin
                    read_op(a);
                    last_wr = 1'b0;
                end
            end
        end

        // controller commands
        for (int n = 0; n < CFG_OPS; n++) begin
            advance_cycle();
            r = next_random();
            cfg_cmd.cfg_wr_en = r[0];
            cfg_cmd.cfg_rd_en = r[1];
            cfg_cmd.cfg_addr = next_random();
            cfg_cmd.cfg_data = next_random();
        end

        wait_reads_done();
        repeat (CFG_HIST_LEN + 2) advance_cycle();
        @(negedge reset);
        $display("%0d mismatches, %0d other errors, %0d reads checked",
                 mismatches, other_errors, reads_due);
        if (mismatches == 0 && other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 16
) (
    // clock, named reset in this project
    output logic reset,
    // active-high asynchronous reset, named clk in this project
    output logic clk
);

    initial begin
        reset = 1'b0;
        forever #(PERIOD_NS / 2) reset = ~reset;
    end

    // released on a falling edge, away from the sampling edge
    initial begin
        clk = 1'b0;
        #1;
        clk = 1'b1;
        #(PERIOD_NS * RESET_CYCLES - 1);
        clk = 1'b0;
    end

endmodule
